// ==== design/core_pkg.sv ====
/*
 * core_pkg: widths, encodings and stage packets shared by the
 * five-stage RV32I pipeline
 */
package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
	// addi x0, x0, 0
	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// major opcodes in inst[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	// internal operations, NOP must stay at zero
	typedef enum logic [3:0] {
		UOP_NOP, UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR, UOP_SLT,
		UOP_LUI, UOP_LW, UOP_SW, UOP_BEQ, UOP_BNE, UOP_JAL
	} uop_e;

	// fetch to decode
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t inst;
	} fetch_pkt_t;

	// decode to execute
	typedef struct packed {
		logic      valid;
		word_t     pc;
		uop_e      uop;
		word_t     rs1_val;
		word_t     rs2_val;
		word_t     imm;
		reg_addr_t rd;
		logic      rd_we;
	} exec_pkt_t;

	// execute to memory, result holds the ALU value or the address
	typedef struct packed {
		uop_e      uop;
		reg_addr_t rd;
		logic      rd_we;
		word_t     result;
		word_t     store_data;
	} mem_pkt_t;

	// register write, also used for every forwarding source
	typedef struct packed {
		logic      rd_we;
		reg_addr_t rd;
		word_t     data;
	} wb_pkt_t;

endpackage

// ==== design/fetch_unit.sv ====
/*
 * fetch_unit: program counter and instruction ROM read, registers the
 * fetched word into the decode stage
 */
module fetch_unit (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   load_stall_i,
	input  logic                   redirect_i,
	input  core_pkg::word_t        redirect_pc_i,
	output core_pkg::word_t        rom_addr_o,
	input  core_pkg::word_t        rom_data_i,
	output core_pkg::fetch_pkt_t   fetch_o
);

	core_pkg::word_t pc_q;

	// ROM answers combinationally on the current pc
	assign rom_addr_o = pc_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc_q <= core_pkg::RESET_PC;
			fetch_o.valid <= 1'b0;
			fetch_o.inst <= core_pkg::NOP_INST;
		end else if (redirect_i) begin
			// redirect wins over a stall, wrong-path word dies here
			pc_q <= redirect_pc_i;
			fetch_o.valid <= 1'b0;
			fetch_o.inst <= core_pkg::NOP_INST;
		end else if (!load_stall_i) begin
			pc_q <= pc_q + 32'd4;
			fetch_o.valid <= 1'b1;
			fetch_o.pc <= pc_q;
			fetch_o.inst <= rom_data_i;
		end
		// stall holds both pc and packet
	end

endmodule

// ==== design/regfile.sv ====
/*
 * regfile: 32 x 32 integer registers, two read ports and one write
 * port with write-through, x0 hard wired to zero
 */
module regfile (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  core_pkg::reg_addr_t   rs1_addr_i,
	input  core_pkg::reg_addr_t   rs2_addr_i,
	output core_pkg::word_t       rs1_data_o,
	output core_pkg::word_t       rs2_data_o,
	input  core_pkg::wb_pkt_t     wb_i
);

	core_pkg::word_t regs_q [1:31];

	// same-cycle write is visible on the read port
	function automatic core_pkg::word_t read_port(input core_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wb_i.rd_we && wb_i.rd == addr)
			return wb_i.data;
		else
			return regs_q[addr];
	endfunction

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 1; i < 32; i++)
				regs_q[i] <= '0;
		end else if (wb_i.rd_we && wb_i.rd != '0) begin
			regs_q[wb_i.rd] <= wb_i.data;
		end
	end

	always_comb begin
		rs1_data_o = read_port(rs1_addr_i);
		rs2_data_o = read_port(rs2_addr_i);
	end

endmodule

// ==== design/decode_unit.sv ====
/*
 * decode_unit: instruction decode, immediates, operand forwarding and
 * load-use detection, registers the packet for execute
 */
module decode_unit (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  core_pkg::fetch_pkt_t   fetch_i,
	output core_pkg::reg_addr_t    rs1_addr_o,
	output core_pkg::reg_addr_t    rs2_addr_o,
	input  core_pkg::word_t        rs1_data_i,
	input  core_pkg::word_t        rs2_data_i,
	input  core_pkg::wb_pkt_t      ex_fwd_i,
	input  logic                   ex_is_load_i,
	input  core_pkg::wb_pkt_t      mem_fwd_i,
	input  logic                   redirect_i,
	output logic                   load_stall_o,
	output core_pkg::exec_pkt_t    exec_o
);

	core_pkg::word_t     inst;
	core_pkg::opcode_e   opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic                use_rs1;
	logic                use_rs2;
	core_pkg::word_t     rs2_fwd;
	core_pkg::exec_pkt_t exec_d;

	// youngest producer first, the register file covers write-back
	function automatic core_pkg::word_t pick_operand(
		input core_pkg::reg_addr_t addr,
		input core_pkg::word_t     rf_val,
		input core_pkg::wb_pkt_t   ex_src,
		input core_pkg::wb_pkt_t   mem_src
	);
		if (addr == '0)
			return '0;
		else if (ex_src.rd_we && ex_src.rd == addr)
			return ex_src.data;
		else if (mem_src.rd_we && mem_src.rd == addr)
			return mem_src.data;
		else
			return rf_val;
	endfunction

	assign inst = fetch_i.inst;
	assign opcode = core_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1_addr_o = inst[19:15];
	assign rs2_addr_o = inst[24:20];

	always_comb begin
		exec_d = '0;
		exec_d.valid = fetch_i.valid;
		exec_d.pc = fetch_i.pc;
		exec_d.rd = inst[11:7];
		exec_d.uop = core_pkg::UOP_NOP;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			core_pkg::OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: exec_d.uop = core_pkg::UOP_ADD;
					10'b0100000_000: exec_d.uop = core_pkg::UOP_SUB;
					10'b0000000_111: exec_d.uop = core_pkg::UOP_AND;
					10'b0000000_110: exec_d.uop = core_pkg::UOP_OR;
					10'b0000000_100: exec_d.uop = core_pkg::UOP_XOR;
					10'b0000000_010: exec_d.uop = core_pkg::UOP_SLT;
					default: exec_d.uop = core_pkg::UOP_NOP;
				endcase
			end
			core_pkg::OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				exec_d.imm = {{20{inst[31]}}, inst[31:20]};
				if (funct3 == 3'b000)
					exec_d.uop = core_pkg::UOP_ADD;
			end
			core_pkg::OPC_LUI: begin
				exec_d.imm = {inst[31:12], 12'b0};
				exec_d.uop = core_pkg::UOP_LUI;
			end
			core_pkg::OPC_LOAD: begin
				use_rs1 = 1'b1;
				exec_d.imm = {{20{inst[31]}}, inst[31:20]};
				if (funct3 == 3'b010)
					exec_d.uop = core_pkg::UOP_LW;
			end
			core_pkg::OPC_STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				exec_d.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				if (funct3 == 3'b010)
					exec_d.uop = core_pkg::UOP_SW;
			end
			core_pkg::OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				exec_d.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
					inst[11:8], 1'b0};
				if (funct3 == 3'b000)
					exec_d.uop = core_pkg::UOP_BEQ;
				else if (funct3 == 3'b001)
					exec_d.uop = core_pkg::UOP_BNE;
			end
			core_pkg::OPC_JAL: begin
				exec_d.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
					inst[30:21], 1'b0};
				exec_d.uop = core_pkg::UOP_JAL;
			end
			default: exec_d.uop = core_pkg::UOP_NOP;
		endcase

		// stores and branches never write rd
		case (exec_d.uop)
			core_pkg::UOP_NOP, core_pkg::UOP_SW,
			core_pkg::UOP_BEQ, core_pkg::UOP_BNE: exec_d.rd_we = 1'b0;
			default: exec_d.rd_we = fetch_i.valid && exec_d.rd != '0;
		endcase

		exec_d.rs1_val = pick_operand(rs1_addr_o, rs1_data_i, ex_fwd_i, mem_fwd_i);
		rs2_fwd = pick_operand(rs2_addr_o, rs2_data_i, ex_fwd_i, mem_fwd_i);
		// immediate ALU ops take the immediate as second operand
		exec_d.rs2_val = (opcode == core_pkg::OPC_OP_IMM) ? exec_d.imm : rs2_fwd;
	end

	// load data only exists one stage later
	assign load_stall_o = fetch_i.valid && ex_is_load_i && ex_fwd_i.rd_we &&
		((use_rs1 && ex_fwd_i.rd == rs1_addr_o) ||
		 (use_rs2 && ex_fwd_i.rd == rs2_addr_o));

	always_ff @(posedge clk_i) begin
		exec_o <= exec_d;
		if (rst_i || redirect_i || load_stall_o) begin
			exec_o.valid <= 1'b0;
			exec_o.uop <= core_pkg::UOP_NOP;
			exec_o.rd_we <= 1'b0;
		end
	end

endmodule

// ==== design/execute_unit.sv ====
/*
 * execute_unit: ALU, branch resolution with fetch redirect and address
 * generation, registers the result for the memory stage
 */
module execute_unit (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  core_pkg::exec_pkt_t   exec_i,
	output core_pkg::wb_pkt_t     ex_fwd_o,
	output logic                  ex_is_load_o,
	output logic                  redirect_o,
	output core_pkg::word_t       redirect_pc_o,
	output core_pkg::mem_pkt_t    mem_o
);

	core_pkg::word_t    rs1;
	core_pkg::word_t    rs2;
	core_pkg::word_t    result;
	logic               taken;
	logic               lt;
	core_pkg::mem_pkt_t mem_d;

	assign rs1 = exec_i.rs1_val;
	assign rs2 = exec_i.rs2_val;
	assign lt = $signed(rs1) < $signed(rs2);

	always_comb begin
		result = '0;
		taken = 1'b0;
		case (exec_i.uop)
			core_pkg::UOP_ADD: result = rs1 + rs2;
			core_pkg::UOP_SUB: result = rs1 - rs2;
			core_pkg::UOP_AND: result = rs1 & rs2;
			core_pkg::UOP_OR:  result = rs1 | rs2;
			core_pkg::UOP_XOR: result = rs1 ^ rs2;
			core_pkg::UOP_SLT: result = {{(core_pkg::XLEN-1){1'b0}}, lt};
			core_pkg::UOP_LUI: result = exec_i.imm;
			core_pkg::UOP_LW, core_pkg::UOP_SW: result = rs1 + exec_i.imm;
			core_pkg::UOP_BEQ: taken = (rs1 == rs2);
			core_pkg::UOP_BNE: taken = (rs1 != rs2);
			core_pkg::UOP_JAL: begin
				// link value
				result = exec_i.pc + 32'd4;
				taken = 1'b1;
			end
			default: result = '0;
		endcase
	end

	// fetch predicts not-taken, so any taken control flow redirects
	assign redirect_o = exec_i.valid && taken;
	assign redirect_pc_o = exec_i.pc + exec_i.imm;

	always_comb begin
		mem_d.uop = exec_i.valid ? exec_i.uop : core_pkg::UOP_NOP;
		mem_d.rd = exec_i.rd;
		mem_d.rd_we = exec_i.valid && exec_i.rd_we;
		mem_d.result = result;
		mem_d.store_data = rs2;
	end

	// a load forwards its address here, decode stalls on it instead
	assign ex_fwd_o = '{rd_we: mem_d.rd_we, rd: exec_i.rd, data: result};
	assign ex_is_load_o = exec_i.valid && exec_i.uop == core_pkg::UOP_LW;

	always_ff @(posedge clk_i) begin
		mem_o <= mem_d;
		if (rst_i) begin
			mem_o.uop <= core_pkg::UOP_NOP;
			mem_o.rd_we <= 1'b0;
		end
	end

endmodule

// ==== design/mem_access.sv ====
/*
 * mem_access: single-cycle data RAM port for word loads and stores,
 * selects the write-back value and registers it
 */
module mem_access (
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  core_pkg::mem_pkt_t    mem_i,
	output logic                  ram_ce_o,
	output logic                  ram_we_o,
	output core_pkg::word_t       ram_addr_o,
	output core_pkg::word_t       ram_data_o,
	input  core_pkg::word_t       ram_data_i,
	output core_pkg::wb_pkt_t     mem_fwd_o,
	output core_pkg::wb_pkt_t     wb_o
);

	logic is_load;
	logic is_store;

	assign is_load = mem_i.uop == core_pkg::UOP_LW;
	assign is_store = mem_i.uop == core_pkg::UOP_SW;

	// word accesses only
	assign ram_ce_o = is_load || is_store;
	assign ram_we_o = is_store;
	assign ram_addr_o = mem_i.result;
	assign ram_data_o = mem_i.store_data;

	// RAM answers in the same cycle
	always_comb begin
		mem_fwd_o.rd_we = mem_i.rd_we;
		mem_fwd_o.rd = mem_i.rd;
		mem_fwd_o.data = is_load ? ram_data_i : mem_i.result;
	end

	always_ff @(posedge clk_i) begin
		wb_o <= mem_fwd_o;
		if (rst_i)
			wb_o.rd_we <= 1'b0;
	end

endmodule

// ==== design/core_top.sv ====
/*
 * core_top: five-stage RV32I pipeline with instruction ROM and data
 * RAM ports
 */
module core_top (
	input  logic              clk_i,
	input  logic              rst_i,

	// instruction ROM, combinational read
	output core_pkg::word_t   rom_addr_o,
	input  core_pkg::word_t   rom_data_i,

	// data RAM, single cycle
	output logic              ram_ce_o,
	output logic              ram_we_o,
	output core_pkg::word_t   ram_addr_o,
	output core_pkg::word_t   ram_data_o,
	input  core_pkg::word_t   ram_data_i
);

	core_pkg::fetch_pkt_t fetch_pkt;
	core_pkg::exec_pkt_t  exec_pkt;
	core_pkg::mem_pkt_t   mem_pkt;
	core_pkg::wb_pkt_t    ex_fwd;
	core_pkg::wb_pkt_t    mem_fwd;
	core_pkg::wb_pkt_t    wb_pkt;

	core_pkg::reg_addr_t  rs1_addr;
	core_pkg::reg_addr_t  rs2_addr;
	core_pkg::word_t      rs1_data;
	core_pkg::word_t      rs2_data;

	logic                 load_stall;
	logic                 ex_is_load;
	logic                 redirect;
	core_pkg::word_t      redirect_pc;

	fetch_unit fetch_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.load_stall_i(load_stall), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.rom_addr_o(rom_addr_o), .rom_data_i(rom_data_i), .fetch_o(fetch_pkt)
	);

	regfile regfile_i (
		.clk_i(clk_i), .rst_i(rst_i),
		.rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .wb_i(wb_pkt)
	);

	decode_unit decode_i (
		.clk_i(clk_i), .rst_i(rst_i), .fetch_i(fetch_pkt),
		.rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
		.rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
		.ex_fwd_i(ex_fwd), .ex_is_load_i(ex_is_load), .mem_fwd_i(mem_fwd),
		.redirect_i(redirect), .load_stall_o(load_stall), .exec_o(exec_pkt)
	);

	execute_unit execute_i (
		.clk_i(clk_i), .rst_i(rst_i), .exec_i(exec_pkt),
		.ex_fwd_o(ex_fwd), .ex_is_load_o(ex_is_load),
		.redirect_o(redirect), .redirect_pc_o(redirect_pc), .mem_o(mem_pkt)
	);

	mem_access mem_i (
		.clk_i(clk_i), .rst_i(rst_i), .mem_i(mem_pkt),
		.ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o),
		.ram_addr_o(ram_addr_o), .ram_data_o(ram_data_o), .ram_data_i(ram_data_i),
		.mem_fwd_o(mem_fwd), .wb_o(wb_pkt)
	);

endmodule

// ==== verif/tb_clock.sv ====
/*
 * tb_clock: 20 ns clock and a 10-cycle synchronous reset, restarted
 * while a reset request is held
 */
module tb_clock (
	input  logic reset_req_i,
	output logic clk_o,
	output logic rst_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [3:0] rst_cnt = 4'd10;

	initial clk_o = 1'b0;
	always #10 clk_o = ~clk_o;

	// counts down the reset cycles after the request drops
	always @(posedge clk_o) begin
		if (reset_req_i)
			rst_cnt <= 4'd10;
		else if (rst_cnt != 4'd0)
			rst_cnt <= rst_cnt - 4'd1;
	end

	assign rst_o = rst_cnt != 4'd0;

endmodule

// ==== verif/tb_memory.sv ====
/*
 * tb_memory: combinational instruction ROM and data RAM models,
 * keeps a log of every store the core makes
 */
module tb_memory (
	input  logic            clk_i,
	input  logic            rst_i,
	input  core_pkg::word_t rom_addr_i,
	output core_pkg::word_t rom_data_o,
	input  logic            ram_ce_i,
	input  logic            ram_we_i,
	input  core_pkg::word_t ram_addr_i,
	input  core_pkg::word_t ram_wdata_i,
	output core_pkg::word_t ram_rdata_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = 256;
	localparam int LOG_DEPTH = 64;

	core_pkg::word_t rom [DEPTH];
	core_pkg::word_t ram [DEPTH];
	core_pkg::word_t log_addr [LOG_DEPTH];
	core_pkg::word_t log_data [LOG_DEPTH];
	int              log_count;

	assign rom_data_o = rom[rom_addr_i[9:2]];
	assign ram_rdata_o = ram_ce_i ? ram[ram_addr_i[9:2]] : '0;

	always @(posedge clk_i) begin
		if (rst_i) begin
			// fill value follows the byte address
			for (int i = 0; i < DEPTH; i++)
				ram[8'(i)] <= 32'h5eed_0000 ^ 32'(i * 4);
			log_count <= 0;
		end else if (ram_ce_i && ram_we_i) begin
			ram[ram_addr_i[9:2]] <= ram_wdata_i;
			if (log_count < LOG_DEPTH) begin
				log_addr[6'(log_count)] <= ram_addr_i;
				log_data[6'(log_count)] <= ram_wdata_i;
			end
			log_count <= log_count + 1;
		end
	end

	task automatic clear_rom();
		for (int i = 0; i < DEPTH; i++)
			rom[8'(i)] = core_pkg::NOP_INST;
	endtask

	task automatic put_inst(input int idx, input core_pkg::word_t inst);
		rom[8'(idx)] = inst;
	endtask

endmodule

// ==== verif/core_tb.sv ====
/*
 * core_tb: directed and random programs for the RV32I pipeline, every
 * data store is checked against values computed here
 */
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STORE_TIMEOUT = 500;
	localparam int DRAIN_CYCLES = 12;
	localparam logic [31:0] SEED = 32'he542;
	localparam int MARKER = 'h666;
	localparam logic [6:0] OPC_R = 7'b0110011;
	localparam logic [6:0] OPC_I = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	logic            clk;
	logic            rst;
	logic            reset_req;
	logic            ram_ce;
	logic            ram_we;
	core_pkg::word_t rom_addr;
	core_pkg::word_t rom_data;
	core_pkg::word_t ram_addr;
	core_pkg::word_t ram_wdata;
	core_pkg::word_t ram_rdata;
	core_pkg::word_t prog [$];
	int              errors;
	int              timeouts;
	int              ram_accesses;

	tb_clock clock_i (.reset_req_i(reset_req), .clk_o(clk), .rst_o(rst));

	tb_memory mem_i (
		.clk_i(clk), .rst_i(rst), .rom_addr_i(rom_addr), .rom_data_o(rom_data),
		.ram_ce_i(ram_ce), .ram_we_i(ram_we), .ram_addr_i(ram_addr),
		.ram_wdata_i(ram_wdata), .ram_rdata_o(ram_rdata)
	);

	core_top dut_i (
		.clk_i(clk), .rst_i(rst), .rom_addr_o(rom_addr), .rom_data_i(rom_data),
		.ram_ce_o(ram_ce), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
		.ram_data_o(ram_wdata), .ram_data_i(ram_rdata)
	);

	// one enabled cycle per load or store in the memory stage
	always @(posedge clk) begin
		if (rst)
			ram_accesses <= 0;
		else if (ram_ce)
			ram_accesses <= ram_accesses + 1;
	end

	function automatic core_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_R};
	endfunction

	function automatic core_pkg::word_t i_type(input logic [6:0] opc, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic core_pkg::word_t store_word(input int rs2, input int rs1, input int imm);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], OPC_STORE};
	endfunction

	function automatic core_pkg::word_t branch_inst(input logic [2:0] f3, input int rs1,
		input int rs2, input int off);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], OPC_BRANCH};
	endfunction

	function automatic core_pkg::word_t upper_imm(input int rd, input logic [19:0] imm20);
		return {imm20, 5'(rd), OPC_LUI};
	endfunction

	function automatic core_pkg::word_t jump_link(input int rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OPC_JAL};
	endfunction

	// lui takes the rounded upper part so that addi's sign lands right
	task automatic load_const(input int rd, input core_pkg::word_t value);
		core_pkg::word_t hi;
		hi = value - {{20{value[11]}}, value[11:0]};
		prog.push_back(upper_imm(rd, hi[31:12]));
		prog.push_back(i_type(OPC_I, 3'b000, rd, rd, int'({20'b0, value[11:0]})));
	endtask

	// reset, load prog into ROM, run until the stores are logged
	task automatic run_program(input string name, input int n_stores);
		int cyc;
		@(posedge clk);
		#1;
		reset_req = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		mem_i.clear_rom();
		foreach (prog[k])
			mem_i.put_inst(k, prog[k]);
		prog.delete();
		reset_req = 1'b0;
		cyc = 0;
		while (mem_i.log_count < n_stores && cyc < STORE_TIMEOUT) begin
			@(posedge clk);
			#1;
			cyc++;
		end
		if (mem_i.log_count < n_stores) begin
			$display("%s did not finish: %0d of %0d stores after %0d cycles",
				name, mem_i.log_count, n_stores, cyc);
			timeouts++;
		end else begin
			// nothing else may be stored once the program spins
			repeat (DRAIN_CYCLES) @(posedge clk);
			#1;
			if (mem_i.log_count != n_stores) begin
				$display("** Error at %0t: %s logged %0d stores, expected %0d",
					$time, name, mem_i.log_count, n_stores);
				errors++;
			end
		end
	endtask

	task automatic expect_store(input int idx, input core_pkg::word_t addr,
		input core_pkg::word_t data);
		if (idx >= mem_i.log_count) begin
			$display("** Error at %0t: store %0d never happened", $time, idx);
			errors++;
		end else if (mem_i.log_addr[6'(idx)] !== addr || mem_i.log_data[6'(idx)] !== data) begin
			$display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
				idx, mem_i.log_data[6'(idx)], mem_i.log_addr[6'(idx)], data, addr);
			errors++;
		end
	endtask

	task automatic expect_accesses(input string name, input int n);
		if (ram_accesses != n) begin
			$display("** Error at %0t: %s enabled the RAM %0d times, expected %0d",
				$time, name, ram_accesses, n);
			errors++;
		end
	endtask

	// each step uses the previous result straight away
	task automatic alu_chain();
		core_pkg::word_t a, b, c, d, e, f, g;
		a = 32'd100;
		b = a - 32'd300;
		c = b + a;
		d = c - a;
		e = d & c;
		f = e | b;
		g = f ^ c;
		prog.push_back(i_type(OPC_I, 3'b000, 1, 0, 100));
		prog.push_back(i_type(OPC_I, 3'b000, 2, 1, -300));
		prog.push_back(r_type(7'b0000000, 3'b000, 3, 2, 1));
		prog.push_back(r_type(7'b0100000, 3'b000, 4, 3, 1));
		prog.push_back(r_type(7'b0000000, 3'b111, 5, 4, 3));
		prog.push_back(r_type(7'b0000000, 3'b110, 6, 5, 2));
		prog.push_back(r_type(7'b0000000, 3'b100, 7, 6, 3));
		prog.push_back(r_type(7'b0000000, 3'b010, 8, 4, 3));
		prog.push_back(r_type(7'b0000000, 3'b010, 9, 3, 4));
		for (int r = 3; r <= 9; r++)
			prog.push_back(store_word(r, 0, (r - 3) * 4));
		prog.push_back(jump_link(0, 0));
		run_program("ALU chain", 7);
		expect_store(0, 32'd0, c);
		expect_store(1, 32'd4, d);
		expect_store(2, 32'd8, e);
		expect_store(3, 32'd12, f);
		expect_store(4, 32'd16, g);
		expect_store(5, 32'd20, ($signed(d) < $signed(c)) ? 32'd1 : 32'd0);
		expect_store(6, 32'd24, ($signed(c) < $signed(d)) ? 32'd1 : 32'd0);
	endtask

	task automatic load_use();
		prog.push_back(i_type(OPC_I, 3'b000, 1, 0, 77));
		prog.push_back(store_word(1, 0, 64));
		prog.push_back(i_type(OPC_LOAD, 3'b010, 2, 0, 64));
		prog.push_back(i_type(OPC_I, 3'b000, 3, 2, 5));
		prog.push_back(store_word(3, 0, 68));
		// untouched word, consumer reads it on rs2
		prog.push_back(i_type(OPC_LOAD, 3'b010, 4, 0, 128));
		prog.push_back(r_type(7'b0000000, 3'b000, 5, 1, 4));
		prog.push_back(store_word(5, 0, 72));
		prog.push_back(jump_link(0, 0));
		run_program("load-use", 3);
		expect_store(0, 32'd64, 32'd77);
		expect_store(1, 32'd68, 32'd82);
		expect_store(2, 32'd72, (32'h5eed_0000 ^ 32'd128) + 32'd77);
		// three stores and two loads
		expect_accesses("load-use", 5);
	endtask

	task automatic branch_skip();
		prog.push_back(i_type(OPC_I, 3'b000, 1, 0, 5));
		prog.push_back(i_type(OPC_I, 3'b000, 2, 0, 5));
		prog.push_back(i_type(OPC_I, 3'b000, 3, 0, 9));
		prog.push_back(i_type(OPC_I, 3'b000, 9, 0, MARKER));
		prog.push_back(branch_inst(3'b000, 1, 2, 8));
		prog.push_back(store_word(9, 0, 0));
		prog.push_back(branch_inst(3'b001, 1, 3, 8));
		prog.push_back(store_word(9, 0, 4));
		prog.push_back(branch_inst(3'b000, 1, 3, 8));
		prog.push_back(store_word(1, 0, 8));
		prog.push_back(branch_inst(3'b001, 1, 2, 8));
		prog.push_back(store_word(3, 0, 12));
		prog.push_back(jump_link(0, 0));
		run_program("branches", 2);
		expect_store(0, 32'd8, 32'd5);
		expect_store(1, 32'd12, 32'd9);
		for (int k = 0; k < mem_i.log_count && k < 64; k++) begin
			if (mem_i.log_data[6'(k)] == 32'(MARKER)) begin
				$display("** Error at %0t: skipped marker store %0d was executed", $time, k);
				errors++;
			end
		end
		expect_accesses("branches", 2);
	endtask

	task automatic jal_link();
		prog.push_back(i_type(OPC_I, 3'b000, 1, 0, 1));
		prog.push_back(jump_link(5, 8));
		prog.push_back(store_word(1, 0, 0));
		prog.push_back(store_word(5, 0, 32));
		prog.push_back(jump_link(0, 0));
		run_program("JAL", 1);
		// JAL sits at address 4
		expect_store(0, 32'd32, 32'd4 + 32'd4);
	endtask

	task automatic x0_and_lui();
		prog.push_back(i_type(OPC_I, 3'b000, 0, 0, 123));
		prog.push_back(store_word(0, 0, 0));
		prog.push_back(upper_imm(1, 20'h12345));
		prog.push_back(i_type(OPC_I, 3'b000, 1, 1, 'h678));
		prog.push_back(store_word(1, 0, 4));
		prog.push_back(upper_imm(2, 20'habcde));
		prog.push_back(i_type(OPC_I, 3'b000, 2, 2, -801));
		prog.push_back(store_word(2, 0, 8));
		prog.push_back(jump_link(0, 0));
		run_program("x0 and LUI", 3);
		expect_store(0, 32'd0, 32'd0);
		expect_store(1, 32'd4, 32'h1234_5678);
		expect_store(2, 32'd8, 32'habcd_e000 - 32'd801);
	endtask

	task automatic random_alu(input int rounds);
		core_pkg::word_t a;
		core_pkg::word_t b;
		for (int r = 0; r < rounds; r++) begin
			a = $urandom;
			b = $urandom;
			load_const(1, a);
			load_const(2, b);
			prog.push_back(store_word(1, 0, 0));
			prog.push_back(store_word(2, 0, 4));
			prog.push_back(r_type(7'b0000000, 3'b000, 3, 1, 2));
			prog.push_back(r_type(7'b0100000, 3'b000, 4, 1, 2));
			prog.push_back(r_type(7'b0000000, 3'b100, 5, 1, 2));
			prog.push_back(store_word(3, 0, 8));
			prog.push_back(store_word(4, 0, 12));
			prog.push_back(store_word(5, 0, 16));
			prog.push_back(jump_link(0, 0));
			run_program("random ALU", 5);
			expect_store(0, 32'd0, a);
			expect_store(1, 32'd4, b);
			expect_store(2, 32'd8, a + b);
			expect_store(3, 32'd12, a - b);
			expect_store(4, 32'd16, a ^ b);
		end
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		reset_req = 1'b1;
		mem_i.clear_rom();
		void'($urandom(SEED));
		alu_chain();
		load_use();
		branch_skip();
		jal_link();
		x0_and_lui();
		random_alu(4);
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
design/core_pkg.sv
design/fetch_unit.sv
design/regfile.sv
design/decode_unit.sv
design/execute_unit.sv
design/mem_access.sv
design/core_top.sv
verif/tb_clock.sv
verif/tb_memory.sv
verif/core_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vcore_tb

.PHONY: all run clean

all: run

$(SIM): sources.f $(wildcard design/*.sv verif/*.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module core_tb \
		-Mdir obj_dir -f sources.f

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
